/* verilog/px_params.svh */
`ifndef PX_PARAMS_SVH
`define PX_PARAMS_SVH

// classifier depth, the delay lines match it
`define PX_CLASSIFY_LAT 4
`define PX_CFG_ADDR_W   5

// target a
`define CFG_A_R0    5'h00
`define CFG_A_G0    5'h01
`define CFG_A_B0    5'h02
`define CFG_A_ERR   5'h03
`define CFG_A_VMIN  5'h04
`define CFG_A_VMAX  5'h05

// target b
`define CFG_B_R0    5'h06
`define CFG_B_G0    5'h07
`define CFG_B_B0    5'h08
`define CFG_B_ERR   5'h09
`define CFG_B_VMIN  5'h0A
`define CFG_B_VMAX  5'h0B

`define CFG_PROC_EN 5'h0C   // bit 0
`define CFG_TAP_SEL 5'h10   // bits 2:0

`define PX_TAP_RAW      3'd0
`define PX_TAP_OVERLAY  3'd1
`define PX_TAP_MASK     3'd2

`define PX_MARK_A   16'hF800    // pure red
`define PX_MARK_B   16'h001F    // pure blue
`define PX_MASK_ON  16'hFFFF
`define PX_MASK_OFF 16'h0000

`endif

/* verilog/px_pkg.sv */
`include "px_params.svh"

package px_pkg;

    // rgb565 as it arrives on the stream
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    typedef logic [5:0] chan6_t;  // one channel after expansion

    typedef struct packed {
        logic hit_a;
        logic hit_b;
    } match_t;

    typedef struct packed {
        logic vs;
        logic de;
    } sync_t;

    // codes 3..7 fall back to raw in the renderer
    typedef enum logic [2:0] {
        TAP_RAW     = `PX_TAP_RAW,
        TAP_OVERLAY = `PX_TAP_OVERLAY,
        TAP_MASK    = `PX_TAP_MASK
    } tap_sel_t;

endpackage

/* verilog/cfg_regfile.sv */
`timescale 1ns/1ns
`include "px_params.svh"

module cfg_regfile (
    input  logic                       post_clk,
    input  logic                       sys_rst_n,
    input  logic                       i_cfg_we,
    input  logic [`PX_CFG_ADDR_W-1:0]  i_cfg_addr,
    input  logic [7:0]                 i_cfg_data,
    output px_pkg::chan6_t             o_a_r0,
    output px_pkg::chan6_t             o_a_g0,
    output px_pkg::chan6_t             o_a_b0,
    output logic [7:0]                 o_a_err,
    output logic [7:0]                 o_a_vmin,
    output logic [7:0]                 o_a_vmax,
    output px_pkg::chan6_t             o_b_r0,
    output px_pkg::chan6_t             o_b_g0,
    output px_pkg::chan6_t             o_b_b0,
    output logic [7:0]                 o_b_err,
    output logic [7:0]                 o_b_vmin,
    output logic [7:0]                 o_b_vmax,
    output logic                       o_proc_en,
    output px_pkg::tap_sel_t           o_tap_sel
);

    always_ff @(posedge post_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            o_a_r0    <= '0;
            o_a_g0    <= '0;
            o_a_b0    <= '0;
            o_a_err   <= '0;
            o_a_vmin  <= '0;
            o_a_vmax  <= '0;
            o_b_r0    <= '0;
            o_b_g0    <= '0;
            o_b_b0    <= '0;
            o_b_err   <= '0;
            o_b_vmin  <= '0;
            o_b_vmax  <= '0;
            o_proc_en <= 1'b0;
            o_tap_sel <= px_pkg::TAP_RAW;
        end else if (i_cfg_we) begin
            case (i_cfg_addr)
                `CFG_A_R0:    o_a_r0    <= i_cfg_data[5:0];   // colour keeps low 6 bits
                `CFG_A_G0:    o_a_g0    <= i_cfg_data[5:0];
                `CFG_A_B0:    o_a_b0    <= i_cfg_data[5:0];
                `CFG_A_ERR:   o_a_err   <= i_cfg_data;
                `CFG_A_VMIN:  o_a_vmin  <= i_cfg_data;
                `CFG_A_VMAX:  o_a_vmax  <= i_cfg_data;
                `CFG_B_R0:    o_b_r0    <= i_cfg_data[5:0];
                `CFG_B_G0:    o_b_g0    <= i_cfg_data[5:0];
                `CFG_B_B0:    o_b_b0    <= i_cfg_data[5:0];
                `CFG_B_ERR:   o_b_err   <= i_cfg_data;
                `CFG_B_VMIN:  o_b_vmin  <= i_cfg_data;
                `CFG_B_VMAX:  o_b_vmax  <= i_cfg_data;
                `CFG_PROC_EN: o_proc_en <= i_cfg_data[0];
                // any 3-bit code is stored, renderer decides what it means
                `CFG_TAP_SEL: o_tap_sel <= px_pkg::tap_sel_t'(i_cfg_data[2:0]);
                default: begin
                    // unmapped address, dropped
                end
            endcase
        end
    end

endmodule

/* verilog/color_classifier.sv */
`timescale 1ns/1ns

module color_classifier (
    input  logic             post_clk,
    input  logic             sys_rst_n,
    input  px_pkg::rgb565_t  i_pixel,
    input  px_pkg::chan6_t   i_a_r0,
    input  px_pkg::chan6_t   i_a_g0,
    input  px_pkg::chan6_t   i_a_b0,
    input  logic [7:0]       i_a_err,
    input  logic [7:0]       i_a_vmin,
    input  logic [7:0]       i_a_vmax,
    input  px_pkg::chan6_t   i_b_r0,
    input  px_pkg::chan6_t   i_b_g0,
    input  px_pkg::chan6_t   i_b_b0,
    input  logic [7:0]       i_b_err,
    input  logic [7:0]       i_b_vmin,
    input  logic [7:0]       i_b_vmax,
    output px_pkg::match_t   o_match
);

    function automatic px_pkg::chan6_t abs_diff(input px_pkg::chan6_t x,
                                                input px_pkg::chan6_t y);
        return (x > y) ? x - y : y - x;
    endfunction

    function automatic px_pkg::chan6_t max3(input px_pkg::chan6_t x,
                                            input px_pkg::chan6_t y,
                                            input px_pkg::chan6_t z);
        px_pkg::chan6_t m;
        m = (x > y) ? x : y;
        return (m > z) ? m : z;
    endfunction

    // stage 1
    px_pkg::chan6_t s1_r, s1_g, s1_b;
    // stage 2
    px_pkg::chan6_t s2_r, s2_g, s2_b;
    px_pkg::chan6_t d_ar, d_ag, d_ab;
    px_pkg::chan6_t d_br, d_bg, d_bb;
    // stage 3
    logic           s3_ok_a, s3_ok_b;
    px_pkg::chan6_t s3_v;

    logic [7:0] v_ext;

    assign v_ext = {2'b00, s3_v};

    always_ff @(posedge post_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            s1_r    <= '0;
            s1_g    <= '0;
            s1_b    <= '0;
            s2_r    <= '0;
            s2_g    <= '0;
            s2_b    <= '0;
            d_ar    <= '0;
            d_ag    <= '0;
            d_ab    <= '0;
            d_br    <= '0;
            d_bg    <= '0;
            d_bb    <= '0;
            s3_ok_a <= 1'b0;
            s3_ok_b <= 1'b0;
            s3_v    <= '0;
            o_match <= '0;
        end else begin
            // expand 5-bit channels with a zero lsb
            s1_r <= {i_pixel.r, 1'b0};
            s1_g <= i_pixel.g;
            s1_b <= {i_pixel.b, 1'b0};

            s2_r <= s1_r;
            s2_g <= s1_g;
            s2_b <= s1_b;
            d_ar <= abs_diff(s1_r, i_a_r0);
            d_ag <= abs_diff(s1_g, i_a_g0);
            d_ab <= abs_diff(s1_b, i_a_b0);
            d_br <= abs_diff(s1_r, i_b_r0);
            d_bg <= abs_diff(s1_g, i_b_g0);
            d_bb <= abs_diff(s1_b, i_b_b0);

            s3_ok_a <= ({2'b00, d_ar} <= i_a_err) && ({2'b00, d_ag} <= i_a_err) &&
                       ({2'b00, d_ab} <= i_a_err);
            s3_ok_b <= ({2'b00, d_br} <= i_b_err) && ({2'b00, d_bg} <= i_b_err) &&
                       ({2'b00, d_bb} <= i_b_err);
            s3_v    <= max3(s2_r, s2_g, s2_b);   // brightness

            o_match.hit_a <= s3_ok_a && (v_ext >= i_a_vmin) && (v_ext <= i_a_vmax);
            o_match.hit_b <= s3_ok_b && (v_ext >= i_b_vmin) && (v_ext <= i_b_vmax);
        end
    end

endmodule

/* verilog/px_delay_line.sv */
`timescale 1ns/1ns
`include "px_params.svh"

module px_delay_line #(
    parameter type T = px_pkg::rgb565_t
) (
    input  logic post_clk,
    input  logic sys_rst_n,
    input  T     i_data,
    output T     o_data
);

    T pipe [`PX_CLASSIFY_LAT];

    always_ff @(posedge post_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            for (int i = 0; i < `PX_CLASSIFY_LAT; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= i_data;
            for (int i = 1; i < `PX_CLASSIFY_LAT; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    // same depth as the classifier
    assign o_data = pipe[`PX_CLASSIFY_LAT-1];

endmodule

/* verilog/px_render.sv */
`timescale 1ns/1ns
`include "px_params.svh"

module px_render (
    input  logic              post_clk,
    input  logic              sys_rst_n,
    input  px_pkg::match_t    i_match,
    input  px_pkg::rgb565_t   i_pixel,
    input  px_pkg::sync_t     i_sync,
    input  logic              i_proc_en,
    input  px_pkg::tap_sel_t  i_tap_sel,
    output logic              o_vs,
    output logic              o_de,
    output px_pkg::rgb565_t   o_data
);

    px_pkg::rgb565_t overlay;
    px_pkg::rgb565_t mask;
    px_pkg::rgb565_t view;

    always_comb begin
        overlay = i_pixel;
        if (i_proc_en) begin
            if (i_match.hit_a) begin
                overlay = px_pkg::rgb565_t'(`PX_MARK_A);   // a wins over b
            end else if (i_match.hit_b) begin
                overlay = px_pkg::rgb565_t'(`PX_MARK_B);
            end
        end
    end

    // mask does not look at proc_en
    assign mask = (i_match.hit_a || i_match.hit_b) ? px_pkg::rgb565_t'(`PX_MASK_ON)
                                                   : px_pkg::rgb565_t'(`PX_MASK_OFF);

    always_comb begin
        case (i_tap_sel)
            px_pkg::TAP_OVERLAY: view = overlay;
            px_pkg::TAP_MASK:    view = mask;
            default:             view = i_pixel;   // raw, also unused codes
        endcase
    end

    always_ff @(posedge post_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            o_vs   <= 1'b0;
            o_de   <= 1'b0;
            o_data <= '0;
        end else begin
            o_vs   <= i_sync.vs;
            o_de   <= i_sync.de;
            o_data <= view;
        end
    end

endmodule

/* verilog/px_pipeline_top.sv */
`timescale 1ns/1ns
`include "px_params.svh"

module px_pipeline_top (
    input  logic                       post_clk,
    input  logic                       sys_rst_n,
    input  logic                       i_cfg_we,
    input  logic [`PX_CFG_ADDR_W-1:0]  i_cfg_addr,
    input  logic [7:0]                 i_cfg_data,
    input  logic                       i_vs,
    input  logic                       i_de,
    input  px_pkg::rgb565_t            i_data,
    output logic                       o_vs,
    output logic                       o_de,
    output px_pkg::rgb565_t            o_data
);

    px_pkg::chan6_t   a_r0, a_g0, a_b0;
    px_pkg::chan6_t   b_r0, b_g0, b_b0;
    logic [7:0]       a_err, a_vmin, a_vmax;
    logic [7:0]       b_err, b_vmin, b_vmax;
    logic             proc_en;
    px_pkg::tap_sel_t tap_sel;

    px_pkg::match_t   match;
    px_pkg::sync_t    sync_in;
    px_pkg::sync_t    sync_dly;
    px_pkg::rgb565_t  pixel_dly;

    assign sync_in.vs = i_vs;
    assign sync_in.de = i_de;

    cfg_regfile u_cfg_regfile (
        .post_clk   (post_clk),
        .sys_rst_n  (sys_rst_n),
        .i_cfg_we   (i_cfg_we),
        .i_cfg_addr (i_cfg_addr),
        .i_cfg_data (i_cfg_data),
        .o_a_r0     (a_r0),
        .o_a_g0     (a_g0),
        .o_a_b0     (a_b0),
        .o_a_err    (a_err),
        .o_a_vmin   (a_vmin),
        .o_a_vmax   (a_vmax),
        .o_b_r0     (b_r0),
        .o_b_g0     (b_g0),
        .o_b_b0     (b_b0),
        .o_b_err    (b_err),
        .o_b_vmin   (b_vmin),
        .o_b_vmax   (b_vmax),
        .o_proc_en  (proc_en),
        .o_tap_sel  (tap_sel)
    );

    // 4 cycles to match
    color_classifier u_color_classifier (
        .post_clk  (post_clk),
        .sys_rst_n (sys_rst_n),
        .i_pixel   (i_data),
        .i_a_r0    (a_r0),
        .i_a_g0    (a_g0),
        .i_a_b0    (a_b0),
        .i_a_err   (a_err),
        .i_a_vmin  (a_vmin),
        .i_a_vmax  (a_vmax),
        .i_b_r0    (b_r0),
        .i_b_g0    (b_g0),
        .i_b_b0    (b_b0),
        .i_b_err   (b_err),
        .i_b_vmin  (b_vmin),
        .i_b_vmax  (b_vmax),
        .o_match   (match)
    );

    px_delay_line #(.T(px_pkg::rgb565_t)) u_pixel_dly (
        .post_clk  (post_clk),
        .sys_rst_n (sys_rst_n),
        .i_data    (i_data),
        .o_data    (pixel_dly)
    );

    px_delay_line #(.T(px_pkg::sync_t)) u_sync_dly (
        .post_clk  (post_clk),
        .sys_rst_n (sys_rst_n),
        .i_data    (sync_in),
        .o_data    (sync_dly)
    );

    // +1 registered output
    px_render u_px_render (
        .post_clk  (post_clk),
        .sys_rst_n (sys_rst_n),
        .i_match   (match),
        .i_pixel   (pixel_dly),
        .i_sync    (sync_dly),
        .i_proc_en (proc_en),
        .i_tap_sel (tap_sel),
        .o_vs      (o_vs),
        .o_de      (o_de),
        .o_data    (o_data)
    );

endmodule

/* test/px_pipeline_sva.sv */
`timescale 1ns/1ns
`include "px_params.svh"

module px_pipeline_sva (
    input logic post_clk,
    input logic sys_rst_n,
    input logic i_vs,
    input logic i_de,
    input logic o_vs,
    input logic o_de
);

    // classifier depth plus the render register
    localparam int LAT = `PX_CLASSIFY_LAT + 1;

    int unsigned run_cnt;   // edges since reset release

    always_ff @(posedge post_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            run_cnt <= 0;
        end else if (run_cnt < LAT) begin
            run_cnt <= run_cnt + 1;
        end
    end

    a_vs_latency: assert property (@(posedge post_clk) disable iff (!sys_rst_n)
        (run_cnt >= LAT) |-> (o_vs == $past(i_vs, LAT)))
        else $error("o_vs is not i_vs delayed by %0d cycles", LAT);

    a_de_latency: assert property (@(posedge post_clk) disable iff (!sys_rst_n)
        (run_cnt >= LAT) |-> (o_de == $past(i_de, LAT)))
        else $error("o_de is not i_de delayed by %0d cycles", LAT);

    // outputs held low while in reset
    a_reset_quiet: assert property (@(posedge post_clk)
        !sys_rst_n |-> (!o_de && !o_vs))
        else $error("o_vs or o_de high during reset");

endmodule

/* test/tb_px_pipeline.sv */
`timescale 1ns/1ns
`include "px_params.svh"

module tb_px_pipeline;

    localparam int RAND_FRAMES = 8;
    localparam int RAND_PIXELS = 50;   // per frame
    // directed part stays well under 1200 cycles
    // a random frame needs well under 3 cycles per pixel plus 40 for setup
    localparam int MAX_CYCLES  = 10 + 1200 + RAND_FRAMES * (RAND_PIXELS * 3 + 40);

    logic                      post_clk;
    logic                      sys_rst_n;
    logic                      i_cfg_we;
    logic [`PX_CFG_ADDR_W-1:0] i_cfg_addr;
    logic [7:0]                i_cfg_data;
    logic                      i_vs;
    logic                      i_de;
    px_pkg::rgb565_t           i_data;
    logic                      o_vs;
    logic                      o_de;
    px_pkg::rgb565_t           o_data;

    // model of the register map
    int         col [2][3];
    int         err [2];
    int         vmin [2];
    int         vmax [2];
    logic       proc_en;
    logic [2:0] tap;

    int              edge_cnt = 0;
    px_pkg::rgb565_t px_q [$];
    px_pkg::rgb565_t exp_pix [$];
    px_pkg::sync_t   exp_sync [$];
    int              exp_due [$];

    px_pipeline_top i_px_pipeline_top (.*);

    bind px_pipeline_top px_pipeline_sva u_px_pipeline_sva (
        .post_clk, .sys_rst_n, .i_vs, .i_de, .o_vs, .o_de
    );

    initial begin
        post_clk = 1'b0;
        forever #4 post_clk = ~post_clk;
    end

    always @(posedge post_clk) edge_cnt <= edge_cnt + 1;

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    initial begin
        #(MAX_CYCLES * 8 + 2000);
        $display("watchdog expired before the tests finished");
        abort_run();
    end

    function automatic px_pkg::rgb565_t mk_pixel(input int r6, input int g6, input int b6);
        px_pkg::rgb565_t p;
        p.r = 5'((r6 & 63) >> 1);
        p.g = 6'(g6 & 63);
        p.b = 5'((b6 & 63) >> 1);
        return p;
    endfunction

    // reference model of the classifier and the renderer
    function automatic px_pkg::rgb565_t expect_view(input px_pkg::rgb565_t p);
        int          ch [3];
        int          v;
        logic [1:0]  hit;
        logic [15:0] res;
        ch[0] = 2 * int'(p.r);
        ch[1] = int'(p.g);
        ch[2] = 2 * int'(p.b);
        v = ch[0];
        for (int c = 1; c < 3; c++) begin
            if (ch[c] > v) begin
                v = ch[c];
            end
        end
        for (int t = 0; t < 2; t++) begin
            hit[t] = (v >= vmin[t]) && (v <= vmax[t]);
            for (int c = 0; c < 3; c++) begin
                if (ch[c] > col[t][c] + err[t] || ch[c] < col[t][c] - err[t]) begin
                    hit[t] = 1'b0;
                end
            end
        end
        res = p;
        if (tap == `PX_TAP_MASK) begin
            res = (hit != 2'b00) ? `PX_MASK_ON : `PX_MASK_OFF;
        end else if (tap == `PX_TAP_OVERLAY && proc_en) begin
            if (hit[0]) begin
                res = `PX_MARK_A;
            end else if (hit[1]) begin
                res = `PX_MARK_B;
            end
        end
        return px_pkg::rgb565_t'(res);
    endfunction

    task automatic check_pixel(input string name, input px_pkg::rgb565_t exp_v,
                               input px_pkg::rgb565_t act_v);
        if (act_v !== exp_v) begin
            $display("ERROR %0t ns %s expected %h got %h", $time, name, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic check_sync(input string name, input px_pkg::sync_t exp_v,
                              input px_pkg::sync_t act_v);
        if (act_v !== exp_v) begin
            $display("ERROR %0t ns %s expected %b got %b", $time, name, exp_v, act_v);
            abort_run();
        end
    endtask

    // compare half a period after the edge
    always @(negedge post_clk) begin
        if (exp_due.size() > 0 && exp_due[0] == edge_cnt) begin
            check_sync("o_vs/o_de", exp_sync.pop_front(), {o_vs, o_de});
            check_pixel("o_data", exp_pix.pop_front(), o_data);
            void'(exp_due.pop_front());
        end
    end

    task automatic step(input logic vs, input logic de, input px_pkg::rgb565_t pix,
                        input logic chk);
        @(posedge post_clk);
        i_vs     <= vs;
        i_de     <= de;
        i_data   <= pix;
        i_cfg_we <= 1'b0;
        if (chk) begin
            exp_pix.push_back(expect_view(pix));
            exp_sync.push_back(px_pkg::sync_t'({vs, de}));
            exp_due.push_back(edge_cnt + 6);   // 5 registers after the sampling edge
        end
    endtask

    task automatic idle(input int n, input logic chk);
        repeat (n) step(1'b0, 1'b0, '0, chk);
    endtask

    task automatic write_cfg(input logic [4:0] addr, input logic [7:0] data);
        int t;
        int f;
        @(posedge post_clk);
        i_cfg_we   <= 1'b1;
        i_cfg_addr <= addr;
        i_cfg_data <= data;
        t = int'(addr) / 6;
        f = int'(addr) % 6;
        if (addr <= `CFG_B_VMAX) begin
            case (f)
                0, 1, 2: col[t][f] = int'(data & 8'h3F);
                3:       err[t] = int'(data);
                4:       vmin[t] = int'(data);
                default: vmax[t] = int'(data);
            endcase
        end else if (addr == `CFG_PROC_EN) begin
            proc_en = data[0];
        end else if (addr == `CFG_TAP_SEL) begin
            tap = data[2:0];
        end
    endtask

    // idle first so nothing checked is still in flight
    task automatic program_target(input int t, input int r, input int g, input int b,
                                  input int e, input int lo, input int hi);
        logic [4:0] base;
        base = (t == 0) ? `CFG_A_R0 : `CFG_B_R0;
        idle(5, 1'b0);
        write_cfg(base, 8'(r));
        write_cfg(base + 5'd1, 8'(g));
        write_cfg(base + 5'd2, 8'(b));
        write_cfg(base + 5'd3, 8'(e));
        write_cfg(base + 5'd4, 8'(lo));
        write_cfg(base + 5'd5, 8'(hi));
    endtask

    task automatic set_view(input logic en, input logic [2:0] code);
        idle(5, 1'b0);
        write_cfg(`CFG_PROC_EN, {7'd0, en});
        write_cfg(`CFG_TAP_SEL, {5'd0, code});
    endtask

    task automatic send_frame();
        step(1'b1, 1'b0, '0, 1'b1);   // vs blanking
        step(1'b1, 1'b0, '0, 1'b1);
        foreach (px_q[i]) begin
            step(1'b0, 1'b1, px_q[i], 1'b1);
        end
        idle(2, 1'b1);
    endtask

    task automatic reset_and_raw();
        @(negedge post_clk);
        check_sync("o_vs/o_de", '0, {o_vs, o_de});
        check_pixel("o_data", '0, o_data);
        idle(6, 1'b1);
        for (int i = 0; i < 16; i++) begin
            px_q.push_back(px_pkg::rgb565_t'($urandom));
        end
        send_frame();
    endtask

    task automatic tolerance_edges();
        program_target(0, 20, 30, 40, 4, 0, 63);
        set_view(1'b1, `PX_TAP_OVERLAY);
        px_q.delete();
        px_q.push_back(mk_pixel(24, 34, 44));   // +err everywhere
        px_q.push_back(mk_pixel(16, 26, 36));   // -err everywhere
        px_q.push_back(mk_pixel(20, 35, 40));   // green err+1
        px_q.push_back(mk_pixel(20, 25, 40));
        px_q.push_back(mk_pixel(26, 30, 40));   // red one step past
        px_q.push_back(mk_pixel(20, 30, 46));
        send_frame();
    endtask

    task automatic window_priority();
        program_target(0, 30, 30, 30, 6, 0, 63);
        program_target(1, 32, 32, 32, 6, 0, 63);
        px_q.delete();
        px_q.push_back(mk_pixel(30, 30, 30));
        px_q.push_back(mk_pixel(34, 32, 28));
        send_frame();
        program_target(0, 30, 30, 30, 6, 0, 29);   // v above a's window
        send_frame();
        program_target(1, 32, 32, 32, 6, 35, 63);
        send_frame();
    endtask

    task automatic mask_and_proc_off();
        set_view(1'b1, `PX_TAP_MASK);
        send_frame();
        program_target(1, 32, 32, 32, 6, 0, 63);
        px_q.push_back(mk_pixel(0, 0, 0));
        send_frame();
        set_view(1'b0, `PX_TAP_MASK);   // mask still on with proc off
        send_frame();
        set_view(1'b0, `PX_TAP_OVERLAY);
        send_frame();
    endtask

    task automatic reg_write_timing();
        set_view(1'b1, `PX_TAP_RAW);
        send_frame();
        set_view(1'b1, `PX_TAP_MASK);
        send_frame();
        idle(5, 1'b0);
        write_cfg(5'h0D, 8'hFF);
        write_cfg(5'h11, 8'h00);
        write_cfg(5'h1A, 8'hFF);   // would close b's window if aliased onto 0x0A
        send_frame();
        set_view(1'b1, 3'd5);
        send_frame();
    endtask

    task automatic random_stream();
        int              t;
        logic            de;
        px_pkg::rgb565_t pix;
        for (int f = 0; f < RAND_FRAMES; f++) begin
            for (int k = 0; k < 2; k++) begin
                program_target(k, $urandom % 64, $urandom % 64, $urandom % 64,
                               $urandom % 12, $urandom % 32, 32 + $urandom % 32);
            end
            set_view(1'($urandom % 2), 3'($urandom % 4));
            step(1'b1, 1'b0, '0, 1'b1);
            for (int i = 0; i < RAND_PIXELS; i++) begin
                t = int'($urandom % 3);
                if (t < 2) begin   // land near a target now and then
                    pix = mk_pixel(col[t][0] + int'($urandom % 7) - 3,
                                   col[t][1] + int'($urandom % 7) - 3,
                                   col[t][2] + int'($urandom % 7) - 3);
                end else begin
                    pix = px_pkg::rgb565_t'($urandom);
                end
                de = ($urandom % 4) != 0;
                step(1'b0, de, pix, 1'b1);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h644635c7));
        sys_rst_n  = 1'b0;
        i_cfg_we   = 1'b0;
        i_cfg_addr = '0;
        i_cfg_data = '0;
        i_vs       = 1'b0;
        i_de       = 1'b0;
        i_data     = '0;
        proc_en    = 1'b0;
        tap        = `PX_TAP_RAW;
        repeat (10) @(posedge post_clk);
        sys_rst_n <= 1'b1;
        reset_and_raw();
        tolerance_edges();
        window_priority();
        mask_and_proc_off();
        reg_write_timing();
        random_stream();
        idle(6, 1'b1);
        repeat (10) begin
            if (exp_due.size() > 0) begin
                @(posedge post_clk);
            end
        end
        if (exp_due.size() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("some expected outputs were never compared");
            abort_run();
        end
    end

endmodule

/* tb.f */
+incdir+verilog
verilog/px_pkg.sv
verilog/cfg_regfile.sv
verilog/color_classifier.sv
verilog/px_delay_line.sv
verilog/px_render.sv
verilog/px_pipeline_top.sv
test/px_pipeline_sva.sv
test/tb_px_pipeline.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the pixel pipeline testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_px_pipeline -o sim_px_pipeline

# a fatal error exits non-zero, the printed output still decides the result
sim_out=$(./obj_dir/sim_px_pipeline 2>&1 || true)
echo "$sim_out"

if grep -q "RESULT: PASS" <<< "$sim_out"; then
    exit 0
fi
echo "pixel pipeline simulation failed"
exit 1
